// ==== files.f ====
src/fma_fmt_pkg.sv
src/fma_op_pkg.sv
src/fma_classifier.sv
src/fma_operand_select.sv
src/fma_align_add.sv
src/fma_normalize_round.sv
src/fma_unit.sv
tb/fma_unit_assertions.sv
tb/fma_unit_tb.sv

// ==== src/fma_align_add.sv ====
// ----------------------------------------------------------
// Exponent path, mantissa product, addend alignment and the
// wide add, closed by the first pipeline register
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fma_align_add (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  fma_op_pkg::fma_adj_t     adj_i,
  input  fma_op_pkg::fma_special_t special_i,
  input  fma_op_pkg::roundmode_e   rnd_mode_i,
  input  logic                     mask_i,
  output fma_op_pkg::fma_mid_t     mid_o
);

  import fma_fmt_pkg::*;
  import fma_op_pkg::*;

  logic signed [EXP_WIDTH-1:0] exp_a, exp_b, exp_c;
  logic signed [EXP_WIDTH-1:0] exp_addend, exp_prod, exp_diff, tent_exp;
  logic [SHAMT_WIDTH-1:0]      addend_shamt;
  logic [PRECISION_BITS-1:0]   man_a, man_b, man_c;
  logic [2*PRECISION_BITS-1:0] product;
  logic [SUM_WIDTH-1:0]        product_shifted;
  logic [SUM_WIDTH-1:0]        addend_after_shift;
  logic [PRECISION_BITS-1:0]   addend_sticky_bits;
  logic [SUM_WIDTH-1:0]        addend_shifted;
  logic                        sticky;
  logic                        eff_sub;
  logic                        tent_sign;
  logic                        carry_in;
  logic [SUM_WIDTH:0]          sum_raw;
  logic [SUM_WIDTH-1:0]        sum;
  logic                        final_sign;
  fma_mid_t                    mid_d;

  // ----------------------------------------------------------
  // Exponent path
  // ----------------------------------------------------------
  // Exponents stay biased, subnormals and zeros count as exponent 1
  assign exp_a      = signed'(EXP_WIDTH'(adj_i.a.exponent));
  assign exp_b      = signed'(EXP_WIDTH'(adj_i.b.exponent));
  assign exp_c      = signed'(EXP_WIDTH'(adj_i.c.exponent));
  assign exp_addend = exp_c + signed'(EXP_WIDTH'(!adj_i.info_c.is_normal));

  // Zero product takes the smallest exponent
  assign exp_prod = (adj_i.info_a.is_zero || adj_i.info_b.is_zero)
                    ? signed'(EXP_WIDTH'(2 - BIAS))
                    : exp_a + signed'(EXP_WIDTH'(adj_i.info_a.is_subnormal))
                      + exp_b + signed'(EXP_WIDTH'(adj_i.info_b.is_subnormal))
                      - signed'(EXP_WIDTH'(BIAS));

  assign exp_diff = exp_addend - exp_prod;
  assign tent_exp = (exp_diff > 0) ? exp_addend : exp_prod;

  always_comb begin : addend_shift_amount
    if (exp_diff <= -2 * PRECISION_BITS - 1) begin
      // Addend lands entirely in the sticky bit
      addend_shamt = SHAMT_WIDTH'(SUM_WIDTH);
    end else if (exp_diff <= PRECISION_BITS + 2) begin
      addend_shamt = SHAMT_WIDTH'(PRECISION_BITS + 3 - exp_diff);
    end else begin
      // Product lands entirely below the addend
      addend_shamt = '0;
    end
  end

  // ----------------------------------------------------------
  // Mantissa path
  // ----------------------------------------------------------
  assign man_a   = {adj_i.info_a.is_normal, adj_i.a.mantissa};
  assign man_b   = {adj_i.info_b.is_normal, adj_i.b.mantissa};
  assign man_c   = {adj_i.info_c.is_normal, adj_i.c.mantissa};
  assign product = man_a * man_b;

  // Product sits above two bits kept for round and sticky
  assign product_shifted = {{(SUM_WIDTH - 2*PRECISION_BITS - 2){1'b0}}, product, 2'b00};

  // Bits shifted past the bottom fold into one sticky bit
  assign {addend_after_shift, addend_sticky_bits} = {man_c, {SUM_WIDTH{1'b0}}} >> addend_shamt;
  assign sticky = |addend_sticky_bits;

  assign eff_sub        = adj_i.a.sign ^ adj_i.b.sign ^ adj_i.c.sign;
  assign tent_sign      = adj_i.a.sign ^ adj_i.b.sign;
  assign addend_shifted = eff_sub ? ~addend_after_shift : addend_after_shift;
  // Two's complement carry, skipped when sticky bits were lost
  assign carry_in       = eff_sub & ~sticky;

  assign sum_raw = product_shifted + addend_shifted + carry_in;

  // No carry out on a subtraction means a negative sum
  assign sum = (eff_sub && !sum_raw[SUM_WIDTH]) ? -sum_raw[SUM_WIDTH-1:0]
                                                : sum_raw[SUM_WIDTH-1:0];
  assign final_sign = eff_sub ? (sum_raw[SUM_WIDTH] == tent_sign) : tent_sign;

  // ----------------------------------------------------------
  // Stage 1 register
  // ----------------------------------------------------------
  assign mid_d = '{
    eff_sub:      eff_sub,
    final_sign:   final_sign,
    exp_prod:     exp_prod,
    exp_diff:     exp_diff,
    tent_exp:     tent_exp,
    addend_shamt: addend_shamt,
    sticky:       sticky,
    sum:          sum,
    rnd_mode:     rnd_mode_i,
    special:      special_i,
    mask:         mask_i
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mid_o <= '0;
    end else begin
      mid_o <= mid_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/fma_classifier.sv ====
// ----------------------------------------------------------
// Operand classifier, purely combinational
// One set of class flags per operand word
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fma_classifier (
  input  fma_fmt_pkg::fp_word_u [2:0] operands_i,
  output fma_fmt_pkg::fp_info_t [2:0] info_o
);

  import fma_fmt_pkg::*;

  for (genvar i = 0; i < 3; i++) begin : gen_class
    logic exp_zero;
    logic exp_ones;
    logic man_zero;

    assign exp_zero = (operands_i[i].fields.exponent == '0);
    assign exp_ones = (operands_i[i].fields.exponent == '1);
    assign man_zero = (operands_i[i].fields.mantissa == '0);

    assign info_o[i].is_normal    = !exp_zero && !exp_ones;
    assign info_o[i].is_subnormal = exp_zero && !man_zero;
    assign info_o[i].is_zero      = exp_zero && man_zero;
    assign info_o[i].is_inf       = exp_ones && man_zero;
    assign info_o[i].is_nan       = exp_ones && !man_zero;
    // Quiet bit is the mantissa MSB
    assign info_o[i].is_signalling = exp_ones && !man_zero
                                     && !operands_i[i].fields.mantissa[MAN_BITS-1];
    assign info_o[i].is_quiet      = exp_ones && operands_i[i].fields.mantissa[MAN_BITS-1];
  end

endmodule

`default_nettype wire

// ==== src/fma_fmt_pkg.sv ====
// ----------------------------------------------------------
// Binary16 format description for the FMA datapath
// Field layout, internal widths and operand class flags
// ----------------------------------------------------------
`default_nettype none

package fma_fmt_pkg;

  // Encoding of binary16
  localparam int EXP_BITS       = 5;
  localparam int MAN_BITS       = 10;
  localparam int BIAS           = 15;
  localparam int PRECISION_BITS = MAN_BITS + 1;
  localparam int FP_WIDTH       = 1 + EXP_BITS + MAN_BITS;

  // Internal datapath widths
  localparam int LOWER_SUM_WIDTH = 2 * PRECISION_BITS + 3;
  localparam int LZC_WIDTH       = $clog2(LOWER_SUM_WIDTH);
  // Wide enough for both the biased exponent range and the LZC result
  localparam int EXP_WIDTH       = 7;
  localparam int SUM_WIDTH       = 3 * PRECISION_BITS + 4;
  localparam int SHAMT_WIDTH     = $clog2(SUM_WIDTH + 1);

  localparam logic [FP_WIDTH-1:0] QNAN_CANON = 16'h7E00;

  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Same operand word seen as raw bits or as fields
  typedef union packed {
    logic [FP_WIDTH-1:0] raw;
    fp_t                 fields;
  } fp_word_u;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

endpackage

`default_nettype wire

// ==== src/fma_normalize_round.sv ====
// ----------------------------------------------------------
// Normalization, rounding, flags and result selection,
// closed by the output register
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fma_normalize_round (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  fma_op_pkg::fma_mid_t  mid_i,
  output fma_fmt_pkg::fp_word_u result_o,
  output fma_op_pkg::status_t   status_o,
  output logic                  mask_o
);

  import fma_fmt_pkg::*;
  import fma_op_pkg::*;

  logic [LOWER_SUM_WIDTH-1:0]   sum_lower;
  logic [LZC_WIDTH-1:0]         lz_count;
  logic signed [EXP_WIDTH-1:0]  lz_count_sgn;
  logic                         lz_empty;
  logic [SHAMT_WIDTH-1:0]       norm_shamt;
  logic signed [EXP_WIDTH-1:0]  norm_exp;
  logic [SUM_WIDTH:0]           sum_shifted;
  logic [PRECISION_BITS:0]      final_man;
  logic [LOWER_SUM_WIDTH-1:0]   sum_sticky_bits;
  logic signed [EXP_WIDTH-1:0]  final_exp;
  logic                         sticky_after_norm;
  logic                         of_before_round;
  logic                         of_after_round;
  logic [EXP_BITS+MAN_BITS-1:0] pre_round_abs;
  logic [EXP_BITS+MAN_BITS-1:0] rounded_abs;
  logic [1:0]                   round_sticky;
  logic                         round_up;
  logic                         rounded_sign;
  fp_word_u                     regular_result;
  status_t                      regular_status;

  // ----------------------------------------------------------
  // Normalization
  // ----------------------------------------------------------
  assign sum_lower = mid_i.sum[LOWER_SUM_WIDTH-1:0];

  // Leading zero count, first one from the MSB wins
  always_comb begin : lzc
    lz_count = '0;
    lz_empty = 1'b1;
    for (int i = 0; i < LOWER_SUM_WIDTH; i++) begin
      if (lz_empty && sum_lower[LOWER_SUM_WIDTH-1-i]) begin
        lz_count = LZC_WIDTH'(i);
        lz_empty = 1'b0;
      end
    end
  end

  assign lz_count_sgn = signed'(EXP_WIDTH'(lz_count));

  always_comb begin : norm_shift_amount
    // Product anchored, or a cancellation that needs the count
    if (mid_i.exp_diff <= 0 || (mid_i.eff_sub && mid_i.exp_diff <= 2)) begin
      if ((mid_i.exp_prod - lz_count_sgn + 1 >= 0) && !lz_empty) begin
        norm_shamt = SHAMT_WIDTH'(PRECISION_BITS + 2 + lz_count);
        norm_exp   = mid_i.exp_prod - lz_count_sgn + 1;
      end else begin
        // Subnormal result, shift capped at the minimum exponent
        norm_shamt = SHAMT_WIDTH'(PRECISION_BITS + 2 + mid_i.exp_prod);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment shift
      norm_shamt = mid_i.addend_shamt;
      norm_exp   = mid_i.tent_exp;
    end
  end

  assign sum_shifted = {1'b0, mid_i.sum} << norm_shamt;

  // One-bit fix-up, the leading one may sit one place off
  always_comb begin : small_norm
    {final_man, sum_sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exp                    = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      {final_man, sum_sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exp                    = norm_exp + 1;
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      final_exp = norm_exp;
    end else if (norm_exp > 1) begin
      {final_man, sum_sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exp                    = norm_exp - 1;
    end else begin
      final_exp = '0;
    end
  end

  assign sticky_after_norm = (|sum_sticky_bits) | mid_i.sticky;

  // ----------------------------------------------------------
  // Rounding
  // ----------------------------------------------------------
  assign of_before_round = (final_exp >= 2**EXP_BITS - 1);

  // Overflow saturates to the largest finite value, rounding then decides
  assign pre_round_abs = of_before_round
                         ? {EXP_BITS'(2**EXP_BITS - 2), {MAN_BITS{1'b1}}}
                         : {final_exp[EXP_BITS-1:0], final_man[MAN_BITS:1]};
  assign round_sticky  = of_before_round ? 2'b11 : {final_man[0], sticky_after_norm};

  always_comb begin : round_decision
    case (mid_i.rnd_mode)
      RNE:     round_up = round_sticky[1] & (round_sticky[0] | pre_round_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky) & mid_i.final_sign;
      RUP:     round_up = (|round_sticky) & ~mid_i.final_sign;
      RMM:     round_up = round_sticky[1];
      default: round_up = 1'b0;
    endcase
  end

  // Carry into the exponent gives the next binade or infinity
  assign rounded_abs = pre_round_abs + (EXP_BITS+MAN_BITS)'(round_up);

  // Exact zero from a subtraction is +0, or -0 under RDN
  assign rounded_sign = (pre_round_abs == '0 && round_sticky == 2'b00 && mid_i.eff_sub)
                        ? (mid_i.rnd_mode == RDN) : mid_i.final_sign;

  assign of_after_round = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '1);

  // ----------------------------------------------------------
  // Flags and result selection
  // ----------------------------------------------------------
  assign regular_result.raw = {rounded_sign, rounded_abs};
  assign regular_status.NV  = 1'b0;
  assign regular_status.DZ  = 1'b0;
  assign regular_status.OF  = of_before_round | of_after_round;
  assign regular_status.NX  = (|round_sticky) | regular_status.OF;
  // Tininess after rounding, only for inexact results
  assign regular_status.UF  = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0)
                              & regular_status.NX;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_o <= '0;
      status_o <= '0;
      mask_o   <= 1'b0;
    end else begin
      result_o <= mid_i.special.is_special ? mid_i.special.result : regular_result;
      status_o <= mid_i.special.is_special ? mid_i.special.status : regular_status;
      mask_o   <= mid_i.mask;
    end
  end

endmodule

`default_nettype wire

// ==== src/fma_op_pkg.sv ====
// ----------------------------------------------------------
// Operation encodings, status flags and the structs that
// carry an operation from one FMA stage to the next
// ----------------------------------------------------------
`default_nettype none

package fma_op_pkg;

  // op_mod selects FMSUB, FNMADD and SUB on top of these
  typedef enum logic [1:0] {
    FMADD  = 2'd0,
    FNMSUB = 2'd1,
    ADD    = 2'd2,
    MUL    = 2'd3
  } operation_e;

  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // Operands after sign and constant adjustment
  typedef struct packed {
    fma_fmt_pkg::fp_t      a;
    fma_fmt_pkg::fp_t      b;
    fma_fmt_pkg::fp_t      c;
    fma_fmt_pkg::fp_info_t info_a;
    fma_fmt_pkg::fp_info_t info_b;
    fma_fmt_pkg::fp_info_t info_c;
  } fma_adj_t;

  // Bypass result for NaN and infinity cases
  typedef struct packed {
    logic                  is_special;
    fma_fmt_pkg::fp_word_u result;
    status_t               status;
  } fma_special_t;

  // Contents of the register after the adder
  typedef struct packed {
    logic                                      eff_sub;
    logic                                      final_sign;
    logic signed [fma_fmt_pkg::EXP_WIDTH-1:0]  exp_prod;
    logic signed [fma_fmt_pkg::EXP_WIDTH-1:0]  exp_diff;
    logic signed [fma_fmt_pkg::EXP_WIDTH-1:0]  tent_exp;
    logic [fma_fmt_pkg::SHAMT_WIDTH-1:0]       addend_shamt;
    logic                                      sticky;
    logic [fma_fmt_pkg::SUM_WIDTH-1:0]         sum;
    roundmode_e                                rnd_mode;
    fma_special_t                              special;
    logic                                      mask;
  } fma_mid_t;

endpackage

`default_nettype wire

// ==== src/fma_operand_select.sv ====
// ----------------------------------------------------------
// Operand adjustment per operation and special-case bypass
// Combinational, feeds the align and add stage
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fma_operand_select (
  input  fma_fmt_pkg::fp_word_u [2:0] operands_i,
  input  fma_fmt_pkg::fp_info_t [2:0] info_i,
  input  fma_op_pkg::operation_e      op_i,
  input  logic                        op_mod_i,
  input  fma_op_pkg::roundmode_e      rnd_mode_i,
  output fma_op_pkg::fma_adj_t        adj_o,
  output fma_op_pkg::fma_special_t    special_o
);

  import fma_fmt_pkg::*;
  import fma_op_pkg::*;

  logic any_nan;
  logic any_snan;
  logic prod_inf;
  logic eff_sub;

  // ----------------------------------------------------------
  // Operand adjustment
  // ----------------------------------------------------------
  always_comb begin : op_select
    adj_o.a      = operands_i[0].fields;
    adj_o.b      = operands_i[1].fields;
    adj_o.c      = operands_i[2].fields;
    adj_o.info_a = info_i[0];
    adj_o.info_b = info_i[1];
    adj_o.info_c = info_i[2];
    // op_mod always negates the addend
    adj_o.c.sign = operands_i[2].fields.sign ^ op_mod_i;

    case (op_i)
      FNMSUB: adj_o.a.sign = ~operands_i[0].fields.sign;
      ADD: begin
        // Multiplier becomes +1.0
        adj_o.a      = '{sign: 1'b0, exponent: EXP_BITS'(BIAS), mantissa: '0};
        adj_o.info_a = '{is_normal: 1'b1, default: 1'b0};
      end
      MUL: begin
        // Zero addend keeps the product sign of a zero product
        adj_o.c      = '{sign: (rnd_mode_i != RDN), exponent: '0, mantissa: '0};
        adj_o.info_c = '{is_zero: 1'b1, default: 1'b0};
      end
      default: ;
    endcase
  end

  // ----------------------------------------------------------
  // Special cases
  // ----------------------------------------------------------
  assign any_nan  = adj_o.info_a.is_nan | adj_o.info_b.is_nan | adj_o.info_c.is_nan;
  assign any_snan = adj_o.info_a.is_signalling | adj_o.info_b.is_signalling
                    | adj_o.info_c.is_signalling;
  assign prod_inf = adj_o.info_a.is_inf | adj_o.info_b.is_inf;
  // Product and addend signs differ
  assign eff_sub  = adj_o.a.sign ^ adj_o.b.sign ^ adj_o.c.sign;

  always_comb begin : special_cases
    special_o.is_special = 1'b0;
    special_o.result.raw = QNAN_CANON;
    special_o.status     = '0;

    // inf * 0 is invalid even with a quiet NaN addend
    if ((adj_o.info_a.is_inf && adj_o.info_b.is_zero)
        || (adj_o.info_a.is_zero && adj_o.info_b.is_inf)) begin
      special_o.is_special = 1'b1;
      special_o.status.NV  = 1'b1;
    end else if (any_nan) begin
      special_o.is_special = 1'b1;
      special_o.status.NV  = any_snan;
    end else if (prod_inf && adj_o.info_c.is_inf && eff_sub) begin
      // inf - inf
      special_o.is_special = 1'b1;
      special_o.status.NV  = 1'b1;
    end else if (prod_inf) begin
      special_o.is_special    = 1'b1;
      special_o.result.fields = '{sign: adj_o.a.sign ^ adj_o.b.sign, exponent: '1,
                                  mantissa: '0};
    end else if (adj_o.info_c.is_inf) begin
      special_o.is_special    = 1'b1;
      special_o.result.fields = '{sign: adj_o.c.sign, exponent: '1, mantissa: '0};
    end
  end

endmodule

`default_nettype wire

// ==== src/fma_unit.sv ====
// ----------------------------------------------------------
// Binary16 fused multiply-add, two-cycle latency
// One operation accepted per clock, mask travels alongside
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fma_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  fma_fmt_pkg::fp_word_u [2:0] operands_i,
  input  fma_op_pkg::operation_e      op_i,
  input  logic                        op_mod_i,
  input  fma_op_pkg::roundmode_e      rnd_mode_i,
  input  logic                        mask_i,
  output fma_fmt_pkg::fp_word_u       result_o,
  output fma_op_pkg::status_t         status_o,
  output logic                        mask_o
);

  fma_fmt_pkg::fp_info_t [2:0] info;
  fma_op_pkg::fma_adj_t        adj;
  fma_op_pkg::fma_special_t    special;
  fma_op_pkg::fma_mid_t        mid;

  fma_classifier u_classifier (
    .operands_i (operands_i),
    .info_o     (info)
  );

  fma_operand_select u_operand_select (
    .operands_i (operands_i),
    .info_i     (info),
    .op_i       (op_i),
    .op_mod_i   (op_mod_i),
    .rnd_mode_i (rnd_mode_i),
    .adj_o      (adj),
    .special_o  (special)
  );

  // Stage 1 ends after the adder
  fma_align_add u_align_add (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .adj_i      (adj),
    .special_i  (special),
    .rnd_mode_i (rnd_mode_i),
    .mask_i     (mask_i),
    .mid_o      (mid)
  );

  // Stage 2 ends at the outputs
  fma_normalize_round u_normalize_round (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .mid_i    (mid),
    .result_o (result_o),
    .status_o (status_o),
    .mask_o   (mask_o)
  );

endmodule

`default_nettype wire

// ==== tb/fma_unit_assertions.sv ====
// ----------------------------------------------------------
// Protocol checks on the FMA top level, bound into fma_unit
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fma_unit_assertions (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  mask_i,
  input logic                  mask_o,
  input fma_fmt_pkg::fp_word_u result_o,
  input fma_op_pkg::status_t   status_o
);

  import fma_fmt_pkg::*;

  // Read by the testbench at the end of the run
  int failures = 0;

  // Mask is a plain level delayed by the two register stages
  mask_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    mask_o == $past(mask_i, 2))
    else begin
      $error("mask_o differs from mask_i two cycles earlier");
      failures++;
    end

  // No division in this unit
  no_div_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    !status_o.DZ)
    else begin
      $error("DZ flag raised");
      failures++;
    end

  // Invalid always returns the canonical quiet NaN
  nv_gives_qnan: assert property (@(posedge clk_i) disable iff (reset_i)
    status_o.NV |-> (result_o.raw == QNAN_CANON))
    else begin
      $error("NV set with a non-canonical result");
      failures++;
    end

endmodule

bind fma_unit fma_unit_assertions u_assertions (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .mask_i   (mask_i),
  .mask_o   (mask_o),
  .result_o (result_o),
  .status_o (status_o)
);

`default_nettype wire

// ==== tb/fma_unit_tb.sv ====
// ----------------------------------------------------------
// Directed testbench for the binary16 FMA unit
// Fused ops, specials, rounding and a back-to-back stream
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fma_unit_tb;

  import fma_fmt_pkg::*;
  import fma_op_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 10;
  localparam int DIRECTED_OPS = 20;
  localparam int STREAM_OPS   = 100;
  // Three cycles per directed op, two to drain the stream, ten times margin
  localparam int TIMEOUT_CYCLES = 10 * (RESET_CYCLES + 3 * DIRECTED_OPS + STREAM_OPS + 2);

  logic           clk;
  logic           reset;
  fp_word_u [2:0] operands;
  operation_e     op;
  logic           op_mod;
  roundmode_e     rnd_mode;
  logic           mask_in;
  fp_word_u       result;
  status_t        status;
  logic           mask_out;

  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  logic [31:0] lcg_state;

  fma_unit u_fma_unit (
    .clk_i      (clk),
    .reset_i    (reset),
    .operands_i (operands),
    .op_i       (op),
    .op_mod_i   (op_mod),
    .rnd_mode_i (rnd_mode),
    .mask_i     (mask_in),
    .result_o   (result),
    .status_o   (status),
    .mask_o     (mask_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Exact encoding of an integer below 2048 in magnitude
  function automatic logic [15:0] int_to_half(input int value);
    int   mag;
    int   msb;
    logic sign;
    sign = (value < 0);
    mag  = sign ? -value : value;
    if (mag == 0) begin
      return {sign, 15'h0000};
    end
    msb = 0;
    for (int i = 0; i < 11; i++) begin
      if (mag[i]) begin
        msb = i;
      end
    end
    // Leading one becomes the hidden bit
    return {sign, 5'(BIAS + msb), 10'((mag << (MAN_BITS - msb)) & 'h3FF)};
  endfunction

  function automatic status_t flags(input logic nv, input logic of, input logic nx);
    return '{NV: nv, DZ: 1'b0, OF: of, UF: 1'b0, NX: nx};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, expected);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic drive_op(input logic [15:0] a, input logic [15:0] b, input logic [15:0] c,
                          input operation_e kind, input logic modifier,
                          input roundmode_e mode, input logic mask);
    operands[0].raw = a;
    operands[1].raw = b;
    operands[2].raw = c;
    op              = kind;
    op_mod          = modifier;
    rnd_mode        = mode;
    mask_in         = mask;
  endtask

  // One operation, checked after the two-cycle latency
  task automatic run_op(input string name, input logic [15:0] a, input logic [15:0] b,
                        input logic [15:0] c, input operation_e kind, input logic modifier,
                        input roundmode_e mode, input logic [15:0] exp_result,
                        input status_t exp_status);
    logic mask;
    lcg_state = lcg_next(lcg_state);
    mask      = lcg_state[24];
    next_cycle();
    drive_op(a, b, c, kind, modifier, mode, mask);
    next_cycle();
    next_cycle();
    check_value({name, " result"}, result.raw, exp_result);
    check_value({name, " status"}, status, exp_status);
    check_value({name, " mask"}, mask_out, mask);
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic test_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    check_value("reset result", result.raw, 16'h0000);
    check_value("reset status", status, 5'b00000);
    check_value("reset mask", mask_out, 1'b0);
  endtask

  task automatic test_fused();
    run_op("fmadd", int_to_half(2), int_to_half(3), int_to_half(1), FMADD, 1'b0, RNE,
           int_to_half(7), flags(0, 0, 0));
    run_op("fmsub", int_to_half(2), int_to_half(3), int_to_half(1), FMADD, 1'b1, RNE,
           int_to_half(5), flags(0, 0, 0));
    run_op("fnmsub", int_to_half(2), int_to_half(3), int_to_half(1), FNMSUB, 1'b0, RNE,
           int_to_half(-5), flags(0, 0, 0));
    run_op("fnmadd", int_to_half(2), int_to_half(3), int_to_half(1), FNMSUB, 1'b1, RNE,
           int_to_half(-7), flags(0, 0, 0));
  endtask

  task automatic test_add_sub_mul();
    // Operand a is not used by ADD
    run_op("add", int_to_half(8), int_to_half(1), int_to_half(2), ADD, 1'b0, RNE,
           int_to_half(3), flags(0, 0, 0));
    run_op("sub", int_to_half(8), int_to_half(1), int_to_half(2), ADD, 1'b1, RNE,
           int_to_half(-1), flags(0, 0, 0));
    run_op("mul", int_to_half(3), int_to_half(4), int_to_half(2), MUL, 1'b0, RNE,
           int_to_half(12), flags(0, 0, 0));
    // Zero product keeps its own sign in every mode
    run_op("mul +0 rdn", 16'h0000, int_to_half(5), 16'h0000, MUL, 1'b0, RDN,
           16'h0000, flags(0, 0, 0));
    run_op("mul +0 rne", 16'h0000, int_to_half(5), 16'h0000, MUL, 1'b0, RNE,
           16'h0000, flags(0, 0, 0));
    run_op("mul -0 rdn", 16'h8000, int_to_half(5), 16'h0000, MUL, 1'b0, RDN,
           16'h8000, flags(0, 0, 0));
  endtask

  task automatic test_specials();
    run_op("inf*0+qnan", 16'h7C00, 16'h0000, 16'h7E00, FMADD, 1'b0, RNE,
           QNAN_CANON, flags(1, 0, 0));
    run_op("snan operand", 16'h3C00, 16'h7D00, 16'h3C00, FMADD, 1'b0, RNE,
           QNAN_CANON, flags(1, 0, 0));
    run_op("qnan operand", 16'h3C00, 16'h3C00, 16'h7F00, FMADD, 1'b0, RNE,
           QNAN_CANON, flags(0, 0, 0));
    run_op("inf-inf", 16'h7C00, 16'h3C00, 16'h7C00, FMADD, 1'b1, RNE,
           QNAN_CANON, flags(1, 0, 0));
    run_op("-inf*2+5", 16'hFC00, int_to_half(2), int_to_half(5), FMADD, 1'b0, RNE,
           16'hFC00, flags(0, 0, 0));
  endtask

  task automatic test_rounding();
    // 1.0 plus half an ulp is an exact tie
    run_op("tie rne", 16'h0000, 16'h3C00, 16'h1000, ADD, 1'b0, RNE,
           16'h3C00, flags(0, 0, 1));
    run_op("tie rtz", 16'h0000, 16'h3C00, 16'h1000, ADD, 1'b0, RTZ,
           16'h3C00, flags(0, 0, 1));
    run_op("tie rup", 16'h0000, 16'h3C00, 16'h1000, ADD, 1'b0, RUP,
           16'h3C01, flags(0, 0, 1));
    run_op("ovf rne", 16'h7BFF, 16'h7BFF, 16'h0000, MUL, 1'b0, RNE,
           16'h7C00, flags(0, 1, 1));
    run_op("ovf rtz", 16'h7BFF, 16'h7BFF, 16'h0000, MUL, 1'b0, RTZ,
           16'h7BFF, flags(0, 1, 1));
  endtask

  // New operation every cycle, results checked in order two cycles later
  task automatic test_stream();
    logic [15:0] exp_result_q[$];
    logic        exp_mask_q[$];
    int          a;
    int          b;
    int          c;
    logic        mask;
    roundmode_e  mode;
    for (int i = 0; i < STREAM_OPS + 2; i++) begin
      next_cycle();
      if (i >= 2) begin
        check_value($sformatf("stream %0d result", i - 2), result.raw,
                    exp_result_q.pop_front());
        check_value($sformatf("stream %0d status", i - 2), status, 5'b00000);
        check_value($sformatf("stream %0d mask", i - 2), mask_out, exp_mask_q.pop_front());
      end
      if (i < STREAM_OPS) begin
        lcg_state = lcg_next(lcg_state);
        a         = int'(lcg_state[19:16]);
        b         = int'(lcg_state[23:20]);
        c         = int'(lcg_state[27:24]);
        mask      = lcg_state[28];
        mode      = roundmode_e'(3'(lcg_state[30:16] % 5));
        drive_op(int_to_half(a), int_to_half(b), int_to_half(c), FMADD, 1'b0, mode, mask);
        // Below 2048, so exact in every mode
        exp_result_q.push_back(int_to_half(a * b + c));
        exp_mask_q.push_back(mask);
      end else begin
        drive_op(16'h0000, 16'h0000, 16'h0000, FMADD, 1'b0, RNE, 1'b0);
      end
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    reset     = 1'b1;
    operands  = '0;
    op        = FMADD;
    op_mod    = 1'b0;
    rnd_mode  = RNE;
    mask_in   = 1'b0;
    lcg_state = 32'd20;

    test_reset();
    test_fused();
    test_add_sub_mul();
    test_specials();
    test_rounding();
    test_stream();
    next_cycle();

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, u_fma_unit.u_assertions.failures);
    if (errors == 0 && u_fma_unit.u_assertions.failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
